//--- compile.f
+incdir+sim
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/rv_core.sv
sim/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f compile.f --top-module tb_rv_core -o tb_rv_core

output=$(./obj_dir/tb_rv_core 2>&1 || true)
echo "$output"

if grep -q "Simulation finished: PASS" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- sim/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH
`default_nettype none

localparam logic [2:0] F3_BEQ = 3'b000;
localparam logic [2:0] F3_BNE = 3'b001;
localparam logic [2:0] F3_BLT = 3'b100;
localparam logic [2:0] F3_BGE = 3'b101;

// Skipped store sw x0, 0(x30)
localparam logic [31:0] SENTINEL_SW = {7'b0, 5'd0, 5'd30, 3'b010, 5'd0, STORE};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

function logic [11:0] rnd12();
  logic [31:0] r;
  r = next_rand();
  return r[11:0];
endfunction

function logic [19:0] rnd20();
  logic [31:0] r;
  r = next_rand();
  return r[19:0];
endfunction

// Word offset inside the load region
function logic [11:0] load_off();
  logic [31:0] r;
  r = next_rand();
  return {2'b00, r[7:0], 2'b00};
endfunction

// Initial data memory contents
function automatic logic [31:0] fill_word(input logic [ADDR_W-1:0] a);
  return ({18'b0, a} * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
endfunction

function automatic logic [31:0] sext12(input logic [11:0] i);
  return {{20{i[11]}}, i};
endfunction

// {instr[30], funct3}
function automatic logic [3:0] funct_of(input alu_op_e op);
  case (op)
    ALU_SUB: return 4'b1000;
    ALU_SLL: return 4'b0001;
    ALU_SLT: return 4'b0010;
    ALU_XOR: return 4'b0100;
    ALU_SRL: return 4'b0101;
    ALU_SRA: return 4'b1101;
    ALU_OR:  return 4'b0110;
    ALU_AND: return 4'b0111;
    default: return 4'b0000;
  endcase
endfunction

// RV32I result semantics
function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
  case (op)
    ALU_SUB:    return a - b;
    ALU_AND:    return a & b;
    ALU_OR:     return a | b;
    ALU_XOR:    return a ^ b;
    ALU_SLT:    return {31'b0, $signed(a) < $signed(b)};
    ALU_SLL:    return a << b[4:0];
    ALU_SRL:    return a >> b[4:0];
    ALU_SRA:    return $unsigned($signed(a) >>> b[4:0]);
    ALU_PASS_B: return b;
    default:    return a + b;
  endcase
endfunction

function automatic logic [31:0] model_word(input logic [ADDR_W-1:0] a);
  return model_mem.exists(a) ? model_mem[a] : fill_word(a);
endfunction

// --------------------
// Program builder
// --------------------
task automatic emit(input logic [31:0] w);
  imem[prog_pc[ADDR_W+1:2]] = w;
  prog_pc = prog_pc + 32'd4;
endtask

task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
  if (rd != 5'd0) begin
    mregs[rd] = v;
  end
endtask

task automatic alu_reg(input alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2);
  logic [3:0] fn;
  fn = funct_of(op);
  emit({1'b0, fn[3], 5'b0, rs2, rs1, fn[2:0], rd, OP});
  set_reg(rd, alu_model(op, mregs[rs1], mregs[rs2]));
endtask

task automatic alu_imm(input alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [11:0] imm);
  logic [3:0] fn;
  fn = funct_of(op);
  emit({imm, rs1, fn[2:0], rd, OP_IMM});
  set_reg(rd, alu_model(op, mregs[rs1], sext12(imm)));
endtask

task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
  emit({imm, rd, LUI});
  set_reg(rd, {imm, 12'b0});
endtask

task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
  logic [31:0] addr;
  addr = mregs[rs1] + sext12(imm);
  emit({imm, rs1, 3'b010, rd, LOAD});
  set_reg(rd, model_word(addr[ADDR_W+1:2]));
endtask

task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                          input logic [11:0] imm);
  logic [31:0] addr;
  store_t      e;
  addr = mregs[rs1] + sext12(imm);
  emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE});
  e.addr = addr[ADDR_W+1:2];
  e.data = mregs[rs2];
  exp_q.push_back(e);
  model_mem[e.addr] = e.data;
endtask

// Results go to consecutive words at 0x1000
task automatic store_result(input logic [4:0] rs2);
  store_word(rs2, 5'd31, store_off);
  store_off = store_off + 12'd4;
endtask

// Branch over one instruction
task automatic branch_skip(input logic [2:0] f3, input logic [4:0] rs1,
                           input logic [4:0] rs2);
  logic taken;
  case (f3)
    F3_BEQ:  taken = (mregs[rs1] == mregs[rs2]);
    F3_BNE:  taken = (mregs[rs1] != mregs[rs2]);
    F3_BLT:  taken = ($signed(mregs[rs1]) < $signed(mregs[rs2]));
    default: taken = ($signed(mregs[rs1]) >= $signed(mregs[rs2]));
  endcase
  emit({7'b0, rs2, rs1, f3, 4'b0100, 1'b0, BRANCH});
  if (taken) begin
    emit(SENTINEL_SW);
  end else begin
    store_result(rs1);
  end
endtask

task automatic jump_skip(input logic [4:0] rd);
  logic [31:0] link;
  link = prog_pc + 32'd4;
  emit({1'b0, 10'b0000000100, 1'b0, 8'b0, rd, JAL});
  emit(SENTINEL_SW);
  set_reg(rd, link);
endtask

task automatic build_program();
  alu_op_e r_ops [9];
  alu_op_e i_ops [5];
  r_ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA};
  i_ops = '{ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT};
  rng_state = 32'd4057;
  prog_pc   = '0;
  store_off = '0;
  for (int i = 0; i < (1 << ADDR_W); i++) begin
    imem[i] = NOP_INSTR;
  end
  for (int i = 0; i < 32; i++) begin
    mregs[i] = '0;
  end
  // Store, sentinel and load bases
  load_upper(5'd31, 20'h1);
  load_upper(5'd30, 20'h2);
  load_upper(5'd29, 20'h3);
  alu_imm(ALU_ADD, 5'd1, 5'd0, rnd12());
  load_upper(5'd2, rnd20());
  alu_imm(ALU_ADD, 5'd2, 5'd2, rnd12());
  // Dependent ALU chains
  foreach (r_ops[k]) begin
    alu_reg(r_ops[k], 5'd5, 5'd1, 5'd2);
    alu_reg(r_ops[k], 5'd6, 5'd5, 5'd1);
    store_result(5'd5);
    store_result(5'd6);
    alu_imm(ALU_XOR, 5'd1, 5'd6, rnd12());
  end
  foreach (i_ops[k]) begin
    alu_imm(i_ops[k], 5'd7, 5'd1, rnd12());
    alu_imm(i_ops[k], 5'd8, 5'd7, rnd12());
    store_result(5'd7);
    store_result(5'd8);
  end
  load_upper(5'd9, rnd20());
  store_result(5'd9);
  // Load-use
  load_word(5'd10, 5'd29, load_off());
  alu_reg(ALU_ADD, 5'd11, 5'd10, 5'd1);
  store_result(5'd11);
  // Taken branches and JAL
  alu_imm(ALU_ADD, 5'd12, 5'd0, 12'hFFB);
  alu_imm(ALU_ADD, 5'd13, 5'd0, 12'd7);
  branch_skip(F3_BEQ, 5'd1, 5'd1);
  branch_skip(F3_BLT, 5'd12, 5'd13);
  jump_skip(5'd14);
  store_result(5'd14);
  // Fall-through with dependent operands
  alu_imm(ALU_ADD, 5'd15, 5'd0, 12'd3);
  branch_skip(F3_BNE, 5'd15, 5'd15);
  alu_imm(ALU_ADD, 5'd13, 5'd0, 12'd9);
  branch_skip(F3_BGE, 5'd12, 5'd13);
  load_word(5'd16, 5'd29, load_off());
  alu_imm(ALU_ADD, 5'd17, 5'd0, 12'd1);
  branch_skip(F3_BNE, 5'd16, 5'd16);
  load_word(5'd16, 5'd29, load_off());
  branch_skip(F3_BNE, 5'd16, 5'd16);
  // Final marker and spin loop
  store_word(5'd1, 5'd30, 12'd4);
  emit({20'b0, 5'd0, JAL});
endtask

`default_nettype wire
`endif

//--- sim/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   data;
  } store_t;

  localparam logic [ADDR_W-1:0] SENTINEL_WADDR = 14'h800;
  localparam logic [ADDR_W-1:0] MARKER_WADDR   = 14'h801;

  logic              clk_i;
  logic              rst_i;
  logic [ADDR_W-1:0] imem_addr_o;
  logic [XLEN-1:0]   imem_data_i;
  logic [ADDR_W-1:0] dmem_addr_o;
  logic [XLEN-1:0]   dmem_wdata_o;
  logic              dmem_we_o;
  logic              dmem_re_o;
  logic [XLEN-1:0]   dmem_rdata_i;

  logic [XLEN-1:0] imem [1 << ADDR_W];
  logic [XLEN-1:0] dmem [1 << ADDR_W];

  // Reference model state
  logic [XLEN-1:0] mregs [32];
  logic [XLEN-1:0] model_mem [logic [ADDR_W-1:0]];
  store_t          exp_q [$];
  logic [XLEN-1:0] prog_pc;
  logic [11:0]     store_off;
  logic [31:0]     rng_state;
  int              exp_total;
  int              store_cnt;
  int              cycle_cnt = 0;
  logic            marker_seen;

  `include "tb_program.svh"

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("[ERROR] t=%0d ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("t=%0d ns %s", $time, why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  rv_core rv_core_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .imem_addr_o  (imem_addr_o),
    .imem_data_i  (imem_data_i),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_re_o    (dmem_re_o),
    .dmem_rdata_i (dmem_rdata_i)
  );

  // Asynchronous reads, data only while the read strobe is high
  assign imem_data_i  = imem[imem_addr_o];
  assign dmem_rdata_i = dmem_re_o ? dmem[dmem_addr_o] : '0;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------
  // Data memory and store checks
  // --------------------
  always @(posedge clk_i) begin : dmem_port
    store_t e;
    cycle_cnt <= cycle_cnt + 1;
    if (rst_i) begin
      for (int i = 0; i < (1 << ADDR_W); i++) begin
        dmem[i] <= fill_word(14'(i));
      end
      store_cnt   <= 0;
      marker_seen <= 1'b0;
    end else if (dmem_we_o) begin
      dmem[dmem_addr_o] <= dmem_wdata_o;
      store_cnt <= store_cnt + 1;
      assert (dmem_addr_o != SENTINEL_WADDR)
        else abort_run("a skipped store reached the sentinel address");
      assert (exp_q.size() > 0)
        else abort_run("the core stored more words than the program holds");
      e = exp_q.pop_front();
      assert (dmem_addr_o == e.addr)
        else value_mismatch("dmem_addr_o", 32'(dmem_addr_o), 32'(e.addr));
      assert (dmem_wdata_o == e.data)
        else value_mismatch("dmem_wdata_o", dmem_wdata_o, e.data);
      if (dmem_addr_o == MARKER_WADDR) begin
        marker_seen <= 1'b1;
      end
    end
  end

  // Memory port quiet in reset and the cycle after
  a_reset_quiet: assert property (@(posedge clk_i)
    ((rst_i && cycle_cnt > 1) || $fell(rst_i)) |-> (!dmem_we_o && !dmem_re_o))
    else abort_run("memory strobe high during or right after reset");

  a_reset_pc: assert property (@(posedge clk_i) $fell(rst_i) |-> imem_addr_o == '0)
    else value_mismatch("imem_addr_o", 32'(imem_addr_o), 32'd0);

  initial begin
    int n;
    rst_i = 1'b1;
    build_program();
    exp_total = exp_q.size();
    repeat (16) @(posedge clk_i);
    #1 rst_i = 1'b0;
    for (n = 0; n < 2000 && !marker_seen; n++) begin
      @(posedge clk_i);
      #2;
    end
    if (!marker_seen) begin
      abort_run("timed out waiting for the final marker store");
    end else if (store_cnt == exp_total) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      value_mismatch("store count", 32'(store_cnt), 32'(exp_total));
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`default_nettype none

module rv_core (
  input  logic                      clk_i,
  input  logic                      rst_i,
  output logic [rv_pkg::ADDR_W-1:0] imem_addr_o,
  input  logic [rv_pkg::XLEN-1:0]   imem_data_i,
  output logic [rv_pkg::ADDR_W-1:0] dmem_addr_o,
  output logic [rv_pkg::XLEN-1:0]   dmem_wdata_o,
  output logic                      dmem_we_o,
  output logic                      dmem_re_o,
  input  logic [rv_pkg::XLEN-1:0]   dmem_rdata_i
);
  import rv_pkg::*;

  logic [XLEN-1:0]       if_id_instr;
  logic [XLEN-1:0]       if_id_pc;
  logic                  stall;
  logic                  branch_taken;
  logic [XLEN-1:0]       branch_target;
  logic                  cmp_fwd_a;
  logic                  cmp_fwd_b;
  logic [REG_ADDR_W-1:0] id_rs1;
  logic [REG_ADDR_W-1:0] id_rs2;
  logic [1:0]            id_uses_rs;
  logic                  id_is_branch;
  logic [XLEN-1:0]       me_rd_data;
  id_ex_t                id_ex;
  ex_me_t                ex_me;
  me_wb_t                me_wb;

  // --------------------
  // Input side
  // --------------------
  fetch_stage fetch_stage_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .stall_i         (stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .imem_addr_o     (imem_addr_o),
    .imem_data_i     (imem_data_i),
    .if_id_instr_o   (if_id_instr),
    .if_id_pc_o      (if_id_pc)
  );

  // --------------------
  // Decode and execute
  // --------------------
  decode_stage decode_stage_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .stall_i         (stall),
    .instr_i         (if_id_instr),
    .pc_i            (if_id_pc),
    .me_rd_data_i    (me_rd_data),
    .cmp_fwd_a_i     (cmp_fwd_a),
    .cmp_fwd_b_i     (cmp_fwd_b),
    .rs1_o           (id_rs1),
    .rs2_o           (id_rs2),
    .uses_rs_o       (id_uses_rs),
    .is_branch_o     (id_is_branch),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .wb_i            (me_wb),
    .id_ex_o         (id_ex)
  );

  hazard_unit hazard_unit_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rs1_i       (id_rs1),
    .rs2_i       (id_rs2),
    .uses_rs_i   (id_uses_rs),
    .is_branch_i (id_is_branch),
    .id_ex_i     (id_ex),
    .ex_me_i     (ex_me),
    .stall_o     (stall),
    .cmp_fwd_a_o (cmp_fwd_a),
    .cmp_fwd_b_o (cmp_fwd_b)
  );

  execute_stage execute_stage_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .id_ex_i (id_ex),
    .me_wb_i (me_wb),
    .ex_me_o (ex_me)
  );

  // Output side
  mem_stage mem_stage_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ex_me_i      (ex_me),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_re_o    (dmem_re_o),
    .dmem_rdata_i (dmem_rdata_i),
    .me_rd_data_o (me_rd_data),
    .me_wb_o      (me_wb)
  );

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
`default_nettype none

module mem_stage (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  rv_pkg::ex_me_t            ex_me_i,
  output logic [rv_pkg::ADDR_W-1:0] dmem_addr_o,
  output logic [rv_pkg::XLEN-1:0]   dmem_wdata_o,
  output logic                      dmem_we_o,
  output logic                      dmem_re_o,
  input  logic [rv_pkg::XLEN-1:0]   dmem_rdata_i,
  output logic [rv_pkg::XLEN-1:0]   me_rd_data_o,
  output rv_pkg::me_wb_t            me_wb_o
);
  import rv_pkg::*;

  // Whole words only
  assign dmem_addr_o  = ex_me_i.alu_result[ADDR_W+1:2];
  assign dmem_wdata_o = ex_me_i.store_data;
  assign dmem_we_o    = ex_me_i.mem_write;
  assign dmem_re_o    = ex_me_i.mem_read;

  assign me_rd_data_o = ex_me_i.mem_read ? dmem_rdata_i : ex_me_i.alu_result;

  // ME/WB register
  always_ff @(posedge clk_i) begin
    me_wb_o.rd      <= ex_me_i.rd;
    me_wb_o.rd_data <= me_rd_data_o;
    if (rst_i) begin
      me_wb_o.reg_write <= 1'b0;
    end else begin
      me_wb_o.reg_write <= ex_me_i.reg_write;
    end
  end

  a_rw_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(dmem_we_o && dmem_re_o));

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`default_nettype none

module execute_stage (
  input  logic           clk_i,
  input  logic           rst_i,
  input  rv_pkg::id_ex_t id_ex_i,
  input  rv_pkg::me_wb_t me_wb_i,
  output rv_pkg::ex_me_t ex_me_o
);
  import rv_pkg::*;

  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_y;
  logic [4:0]      shamt;
  ex_me_t          ex_me_d;

  // Youngest producer first
  function automatic fwd_sel_e fwd_select(input logic [REG_ADDR_W-1:0] rs,
                                          input ex_me_t me, input me_wb_t wb);
    fwd_sel_e sel;
    if (me.reg_write && me.rd != '0 && me.rd == rs) begin
      sel = FWD_ME;
    end else if (wb.reg_write && wb.rd != '0 && wb.rd == rs) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] reg_val,
                                              input logic [XLEN-1:0] me_val,
                                              input logic [XLEN-1:0] wb_val);
    logic [XLEN-1:0] val;
    case (sel)
      FWD_ME:  val = me_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  // --------------------
  // Operand forwarding
  // --------------------
  assign fwd_a   = fwd_select(id_ex_i.rs1, ex_me_o, me_wb_i);
  assign fwd_b   = fwd_select(id_ex_i.rs2, ex_me_o, me_wb_i);
  assign rs1_val = fwd_mux(fwd_a, id_ex_i.rs1_data, ex_me_o.alu_result, me_wb_i.rd_data);
  assign rs2_val = fwd_mux(fwd_b, id_ex_i.rs2_data, ex_me_o.alu_result, me_wb_i.rd_data);

  // JAL link value is PC+4
  assign alu_a = id_ex_i.ctrl.link ? id_ex_i.pc : rs1_val;
  assign alu_b = id_ex_i.ctrl.link     ? XLEN'(4) :
                 id_ex_i.ctrl.b_is_imm ? id_ex_i.imm : rs2_val;
  assign shamt = alu_b[4:0];

  // --------------------
  // ALU
  // --------------------
  always_comb begin
    case (id_ex_i.ctrl.alu_op)
      ALU_SUB:    alu_y = alu_a - alu_b;
      ALU_AND:    alu_y = alu_a & alu_b;
      ALU_OR:     alu_y = alu_a | alu_b;
      ALU_XOR:    alu_y = alu_a ^ alu_b;
      ALU_SLT:    alu_y = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLL:    alu_y = alu_a << shamt;
      ALU_SRL:    alu_y = alu_a >> shamt;
      ALU_SRA:    alu_y = $unsigned($signed(alu_a) >>> shamt);
      ALU_PASS_B: alu_y = alu_b;
      default:    alu_y = alu_a + alu_b;
    endcase
  end

  // EX/ME register
  always_comb begin
    ex_me_d.reg_write  = id_ex_i.ctrl.reg_write;
    ex_me_d.mem_read   = id_ex_i.ctrl.mem_read;
    ex_me_d.mem_write  = id_ex_i.ctrl.mem_write;
    ex_me_d.rd         = id_ex_i.rd;
    ex_me_d.alu_result = alu_y;
    ex_me_d.store_data = rs2_val;
  end

  always_ff @(posedge clk_i) begin
    ex_me_o <= ex_me_d;
    if (rst_i) begin
      ex_me_o.reg_write <= 1'b0;
      ex_me_o.mem_read  <= 1'b0;
      ex_me_o.mem_write <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`default_nettype none

module hazard_unit (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [1:0]                    uses_rs_i,
  input  logic                          is_branch_i,
  input  rv_pkg::id_ex_t                id_ex_i,
  input  rv_pkg::ex_me_t                ex_me_i,
  output logic                          stall_o,
  output logic                          cmp_fwd_a_o,
  output logic                          cmp_fwd_b_o
);

  logic ex_hit;
  logic me_hit;
  logic load_use;
  logic branch_ex;
  logic branch_me;

  // ID source matches a non-zero rd further down
  assign ex_hit = (id_ex_i.rd != '0) &&
                  ((uses_rs_i[0] && rs1_i == id_ex_i.rd) ||
                   (uses_rs_i[1] && rs2_i == id_ex_i.rd));
  assign me_hit = (ex_me_i.rd != '0) &&
                  ((uses_rs_i[0] && rs1_i == ex_me_i.rd) ||
                   (uses_rs_i[1] && rs2_i == ex_me_i.rd));

  assign load_use  = id_ex_i.ctrl.mem_read && ex_hit;
  assign branch_ex = is_branch_i && id_ex_i.ctrl.reg_write && ex_hit;
  assign branch_me = is_branch_i && ex_me_i.mem_read && me_hit;
  assign stall_o   = load_use || branch_ex || branch_me;

  // Comparator takes the ME result, WB comes through the register file
  assign cmp_fwd_a_o = ex_me_i.reg_write && (ex_me_i.rd != '0) && (ex_me_i.rd == rs1_i);
  assign cmp_fwd_b_o = ex_me_i.reg_write && (ex_me_i.rd != '0) && (ex_me_i.rd == rs2_i);

  // The bubble behind a load clears the hazard after one cycle
  a_load_use_once: assert property (@(posedge clk_i) disable iff (rst_i)
    load_use |=> !load_use);

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`default_nettype none

module decode_stage (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          stall_i,
  input  logic [rv_pkg::XLEN-1:0]       instr_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  input  logic [rv_pkg::XLEN-1:0]       me_rd_data_i,
  input  logic                          cmp_fwd_a_i,
  input  logic                          cmp_fwd_b_i,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [1:0]                    uses_rs_o,
  output logic                          is_branch_o,
  output logic                          branch_taken_o,
  output logic [rv_pkg::XLEN-1:0]       branch_target_o,
  input  rv_pkg::me_wb_t                wb_i,
  output rv_pkg::id_ex_t                id_ex_o
);
  import rv_pkg::*;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [REG_ADDR_W-1:0] rd;
  ctrl_t                 ctrl;
  logic                  is_jal;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_s;
  logic [XLEN-1:0]       imm_b;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       imm_j;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       cmp_a;
  logic [XLEN-1:0]       cmp_b;
  logic                  cond;
  id_ex_t                id_ex_d;

  // instr[30] picks SUB and SRA
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      3'b111:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  // --------------------
  // Fields and immediates
  // --------------------
  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign rd     = instr_i[11:7];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Main control with uses_rs_o[0] for rs1 and [1] for rs2
  always_comb begin
    ctrl        = '0;
    uses_rs_o   = 2'b00;
    is_branch_o = 1'b0;
    is_jal      = 1'b0;
    imm         = imm_i;
    case (opcode)
      OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, instr_i[30], 1'b1);
        uses_rs_o      = 2'b11;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, instr_i[30], 1'b0);
        ctrl.b_is_imm  = 1'b1;
        uses_rs_o      = 2'b01;
      end
      LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.b_is_imm  = 1'b1;
        imm            = imm_u;
      end
      LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        uses_rs_o      = 2'b01;
      end
      STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        uses_rs_o      = 2'b11;
        imm            = imm_s;
      end
      BRANCH: begin
        is_branch_o = 1'b1;
        uses_rs_o   = 2'b11;
        imm         = imm_b;
      end
      JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.link      = 1'b1;
        is_jal         = 1'b1;
        imm            = imm_j;
      end
      default: ;
    endcase
  end

  reg_file reg_file_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_i      (rs1_o),
    .rs2_i      (rs2_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb_i)
  );

  // --------------------
  // Branch resolution
  // --------------------
  assign cmp_a = cmp_fwd_a_i ? me_rd_data_i : rs1_data;
  assign cmp_b = cmp_fwd_b_i ? me_rd_data_i : rs2_data;

  always_comb begin
    case (funct3)
      3'b000:  cond = (cmp_a == cmp_b);
      3'b001:  cond = (cmp_a != cmp_b);
      3'b100:  cond = ($signed(cmp_a) < $signed(cmp_b));
      3'b101:  cond = ($signed(cmp_a) >= $signed(cmp_b));
      default: cond = 1'b0;
    endcase
  end

  // Operands are not valid yet while stalled
  assign branch_taken_o  = ((is_branch_o && cond) || is_jal) && !stall_i;
  assign branch_target_o = pc_i + imm;

  // ID/EX register
  always_comb begin
    id_ex_d          = '0;
    id_ex_d.ctrl     = ctrl;
    id_ex_d.pc       = pc_i;
    id_ex_d.rs1      = rs1_o;
    id_ex_d.rs2      = rs2_o;
    id_ex_d.rd       = rd;
    id_ex_d.rs1_data = rs1_data;
    id_ex_d.rs2_data = rs2_data;
    id_ex_d.imm      = imm;
  end

  always_ff @(posedge clk_i) begin
    id_ex_o <= id_ex_d;
    if (rst_i || stall_i) begin
      id_ex_o.ctrl <= '0;
    end
  end

  // A held branch is decoded again on the next cycle
  a_stall_holds_id: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> ($stable(instr_i) && $stable(pc_i)));

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`default_nettype none

module reg_file (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
  input  rv_pkg::me_wb_t                wb_i
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];
  logic            wr_en;

  // x0 is never written so it stays zero
  assign wr_en = wb_i.reg_write && (wb_i.rd != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_i.rd] <= wb_i.rd_data;
    end
  end

  // Write-through bypass
  assign rs1_data_o = (wr_en && wb_i.rd == rs1_i) ? wb_i.rd_data : regs[rs1_i];
  assign rs2_data_o = (wr_en && wb_i.rd == rs2_i) ? wb_i.rd_data : regs[rs2_i];

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`default_nettype none

module fetch_stage (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      stall_i,
  input  logic                      branch_taken_i,
  input  logic [rv_pkg::XLEN-1:0]   branch_target_i,
  output logic [rv_pkg::ADDR_W-1:0] imem_addr_o,
  input  logic [rv_pkg::XLEN-1:0]   imem_data_i,
  output logic [rv_pkg::XLEN-1:0]   if_id_instr_o,
  output logic [rv_pkg::XLEN-1:0]   if_id_pc_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_next;

  // Word address into instruction memory
  assign imem_addr_o = pc[ADDR_W+1:2];

  // Stall wins over a taken branch
  always_comb begin
    if (stall_i) begin
      pc_next = pc;
    end else if (branch_taken_i) begin
      pc_next = branch_target_i;
    end else begin
      pc_next = pc + XLEN'(4);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // IF/ID register, flushed to a NOP behind a taken branch
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      if_id_instr_o <= NOP_INSTR;
    end else if (!stall_i) begin
      if_id_instr_o <= branch_taken_i ? NOP_INSTR : imem_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      if_id_pc_o <= pc;
    end
  end

  a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i) pc[1:0] == 2'b00);

  a_addr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> $stable(imem_addr_o));

endmodule

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int ADDR_W     = 14;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_ME,
    FWD_WB
  } fwd_sel_e;

  // --------------------
  // Pipeline registers
  // --------------------

  // All zero is a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    alu_op_e alu_op;
    logic    b_is_imm;
    logic    link;     // result is PC+4
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
  } id_ex_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       store_data;
  } ex_me_t;

  typedef struct packed {
    logic                  reg_write;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rd_data;
  } me_wb_t;

endpackage

`default_nettype wire
